// ==== source/fpu_if_pkg.sv ====
package fpu_if_pkg;

    // ==================================================
    // Data path and size codes
    // ==================================================

    localparam int DATA_W = 80;     // Widest operand, 8087 temp real
    localparam int SIZE_W = 2;

    localparam logic [SIZE_W-1:0] SIZE_16 = 2'd0;
    localparam logic [SIZE_W-1:0] SIZE_32 = 2'd1;
    localparam logic [SIZE_W-1:0] SIZE_64 = 2'd2;
    localparam logic [SIZE_W-1:0] SIZE_80 = 2'd3;

    // ==================================================
    // ESC opcodes and ModR/M
    // ==================================================

    localparam logic [7:0] ESC_D8 = 8'hD8;
    localparam logic [7:0] ESC_D9 = 8'hD9;
    localparam logic [7:0] ESC_DA = 8'hDA;
    localparam logic [7:0] ESC_DB = 8'hDB;
    localparam logic [7:0] ESC_DC = 8'hDC;
    localparam logic [7:0] ESC_DD = 8'hDD;
    localparam logic [7:0] ESC_DE = 8'hDE;
    localparam logic [7:0] ESC_DF = 8'hDF;

    localparam logic [1:0] MOD_REG        = 2'd3;   // Register form, no memory operand
    localparam logic [7:0] FSTSW_AX_MODRM = 8'hE0;  // DF E0 stores status to AX

    // ModR/M byte, seen whole or split into its fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] mod;
            logic [2:0] op_reg;     // reg field, opcode extension
            logic [2:0] rm;
        } f;
    } modrm_u;

    // ==================================================
    // Control and status
    // ==================================================

    localparam logic [15:0] CTRL_WORD_DEFAULT = 16'h037F;  // All exceptions masked
    localparam int          STATUS_MASK_BIT   = 7;

    // Transaction states
    localparam logic [2:0] ST_IDLE         = 3'd0;
    localparam logic [2:0] ST_OPERAND_WAIT = 3'd1;
    localparam logic [2:0] ST_EXECUTE      = 3'd2;
    localparam logic [2:0] ST_RESULT       = 3'd3;
    localparam logic [2:0] ST_COMPLETE     = 3'd4;

endpackage

// ==== source/esc_decoder.sv ====
`timescale 1ns/1ps

module esc_decoder import fpu_if_pkg::*; (
    input  logic [7:0]        opcode,
    input  modrm_u            modrm,
    output logic              needs_operand,
    output logic              produces_result,
    output logic [SIZE_W-1:0] op_size
);

    logic mem_form;

    assign mem_form = (modrm.f.mod != MOD_REG);

    // ==================================================
    // Decode table
    // ==================================================

    always_comb begin
        // Register forms and unknown opcodes fall through to these
        needs_operand   = 1'b0;
        produces_result = 1'b0;
        op_size         = SIZE_16;

        case (opcode)
            ESC_D8, ESC_DA: begin   // Real / int32 arithmetic
                if (mem_form) begin
                    needs_operand = 1'b1;
                    op_size       = SIZE_32;
                end
            end

            ESC_D9: begin
                if (mem_form) begin
                    case (modrm.f.op_reg)
                        3'd0: begin     // FLD m32
                            needs_operand = 1'b1;
                            op_size       = SIZE_32;
                        end
                        3'd2: begin     // FST m32
                            produces_result = 1'b1;
                            op_size         = SIZE_32;
                        end
                        3'd5: begin     // FLDCW
                            needs_operand = 1'b1;
                        end
                        3'd7: begin     // FSTCW
                            produces_result = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end

            ESC_DB: begin
                if (mem_form) begin
                    case (modrm.f.op_reg)
                        3'd5: begin     // FLD m80
                            needs_operand = 1'b1;
                            op_size       = SIZE_80;
                        end
                        3'd7: begin     // FSTP m80
                            produces_result = 1'b1;
                            op_size         = SIZE_80;
                        end
                        default: begin  // Integer loads, 32-bit
                            needs_operand = 1'b1;
                            op_size       = SIZE_32;
                        end
                    endcase
                end
            end

            ESC_DC: begin   // Double-precision arithmetic
                if (mem_form) begin
                    needs_operand = 1'b1;
                    op_size       = SIZE_64;
                end
            end

            ESC_DD: begin
                if (mem_form) begin
                    case (modrm.f.op_reg)
                        3'd0: begin     // FLD m64
                            needs_operand = 1'b1;
                            op_size       = SIZE_64;
                        end
                        3'd2: begin     // FST m64
                            produces_result = 1'b1;
                            op_size         = SIZE_64;
                        end
                        3'd7: begin     // FSTSW m16
                            produces_result = 1'b1;
                        end
                        default: ;
                    endcase
                end
            end

            ESC_DE: begin   // int16 arithmetic
                if (mem_form) begin
                    needs_operand = 1'b1;
                end
            end

            ESC_DF: begin
                // FSTSW AX is a register form that still returns a word
                if (modrm.raw == FSTSW_AX_MODRM) begin
                    produces_result = 1'b1;
                end else if (mem_form) begin
                    needs_operand = 1'b1;
                end
            end

            default: ;  // Still forwarded to the core
        endcase
    end

endmodule

// ==== source/fpu_sequencer.sv ====
`timescale 1ns/1ps

module fpu_sequencer import fpu_if_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // CPU instruction side
    input  logic              cpu_fpu_instr_valid,
    input  logic [7:0]        cpu_fpu_opcode,
    input  modrm_u            cpu_fpu_modrm,
    input  logic              needs_operand,
    input  logic              produces_result,
    input  logic [SIZE_W-1:0] op_size,
    input  logic              cpu_fpu_data_write,
    input  logic              cpu_fpu_data_read,
    input  logic              cpu_fpu_ctrl_write,
    input  logic [15:0]       cpu_fpu_control_word,

    // Core side
    input  logic              fpu_operation_complete,
    input  logic [15:0]       fpu_status,
    input  logic              fpu_error,

    output logic              cpu_fpu_instr_ack,
    output logic              cpu_fpu_busy,
    output logic              cpu_fpu_ready,
    output logic              cpu_fpu_data_ready,
    output logic [SIZE_W-1:0] cpu_fpu_operand_size,
    output logic [15:0]       cpu_fpu_status_word,
    output logic              cpu_fpu_exception,
    output logic              cpu_fpu_irq,

    output logic              fpu_start,
    output logic [7:0]        fpu_operation,
    output logic [7:0]        fpu_operand_select,
    output logic [15:0]       fpu_control_reg,
    output logic              fpu_control_update,

    // Operand path controls
    output logic              clear_operand,
    output logic              capture_operand,
    output logic              capture_result,
    output logic [SIZE_W-1:0] size_q
);

    logic [2:0] state;
    logic [2:0] next_state;
    logic [7:0] opcode_q;
    modrm_u     modrm_q;
    logic       result_q;       // Latched produces_result
    logic       accept;
    logic       ctrl_take;

    assign accept    = (state == ST_IDLE) && cpu_fpu_instr_valid;
    assign ctrl_take = (state == ST_IDLE) && cpu_fpu_ctrl_write;

    // ==================================================
    // Transaction FSM
    // ==================================================

    always_comb begin
        next_state = state;
        case (state)
            ST_IDLE: begin
                // Decode comes straight from the live bytes here
                if (cpu_fpu_instr_valid) begin
                    next_state = needs_operand ? ST_OPERAND_WAIT : ST_EXECUTE;
                end
            end
            ST_OPERAND_WAIT: if (cpu_fpu_data_write) next_state = ST_EXECUTE;
            ST_EXECUTE: begin
                if (fpu_operation_complete) begin
                    next_state = result_q ? ST_RESULT : ST_COMPLETE;
                end
            end
            ST_RESULT:   if (cpu_fpu_data_read) next_state = ST_COMPLETE;
            ST_COMPLETE: next_state = ST_IDLE;
            default:     next_state = ST_IDLE;
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state              <= ST_IDLE;
            cpu_fpu_instr_ack  <= 1'b0;
            fpu_start          <= 1'b0;
            opcode_q           <= 8'h00;
            modrm_q            <= '0;
            result_q           <= 1'b0;
            size_q             <= SIZE_16;
        end else begin
            state             <= next_state;
            cpu_fpu_instr_ack <= accept;
            // High only in the first EXECUTE cycle
            fpu_start <= (next_state == ST_EXECUTE) && (state != ST_EXECUTE);
            if (accept) begin
                opcode_q <= cpu_fpu_opcode;
                modrm_q  <= cpu_fpu_modrm;
                result_q <= produces_result;
                size_q   <= op_size;
            end
        end
    end

    // ==================================================
    // Control word register
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fpu_control_reg    <= CTRL_WORD_DEFAULT;
            fpu_control_update <= 1'b0;
        end else begin
            fpu_control_update <= ctrl_take;
            if (ctrl_take) fpu_control_reg <= cpu_fpu_control_word;  // Idle only
        end
    end

    // Operand path strobes
    assign clear_operand   = accept;
    assign capture_operand = (state == ST_OPERAND_WAIT) && cpu_fpu_data_write;
    assign capture_result  = (state == ST_EXECUTE) && fpu_operation_complete;

    assign cpu_fpu_busy         = (state != ST_IDLE);
    assign cpu_fpu_ready        = ~cpu_fpu_busy;
    assign cpu_fpu_data_ready   = (state == ST_RESULT);
    assign cpu_fpu_operand_size = size_q;
    assign fpu_operation        = opcode_q;
    assign fpu_operand_select   = modrm_q.raw;

    // Status passes through, error counts only when unmasked
    assign cpu_fpu_status_word = fpu_status;
    assign cpu_fpu_exception   = fpu_error && !fpu_status[STATUS_MASK_BIT];
    assign cpu_fpu_irq         = cpu_fpu_exception;

endmodule

// ==== source/operand_path.sv ====
`timescale 1ns/1ps

module operand_path import fpu_if_pkg::*; (
    input  logic              clk,
    input  logic              reset,
    input  logic              clear_operand,
    input  logic              capture_operand,
    input  logic              capture_result,
    input  logic [SIZE_W-1:0] size_q,
    input  logic [DATA_W-1:0] cpu_fpu_data_in,
    input  logic [DATA_W-1:0] fpu_result_data,
    output logic [DATA_W-1:0] fpu_operand_data,
    output logic [DATA_W-1:0] cpu_fpu_data_out
);

    // Keep only the low bits of the selected width
    function automatic logic [DATA_W-1:0] mask_to_size(
        input logic [DATA_W-1:0] data,
        input logic [SIZE_W-1:0] size
    );
        logic [DATA_W-1:0] mask;
        case (size)
            SIZE_16: mask = {{(DATA_W-16){1'b0}}, {16{1'b1}}};
            SIZE_32: mask = {{(DATA_W-32){1'b0}}, {32{1'b1}}};
            SIZE_64: mask = {{(DATA_W-64){1'b0}}, {64{1'b1}}};
            default: mask = {DATA_W{1'b1}};
        endcase
        return data & mask;
    endfunction

    // ==================================================
    // Operand buffer
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            fpu_operand_data <= '0;
        end else if (clear_operand) begin
            fpu_operand_data <= '0;     // No-operand instructions send zero
        end else if (capture_operand) begin
            fpu_operand_data <= mask_to_size(cpu_fpu_data_in, size_q);
        end
    end

    // ==================================================
    // Result buffer
    // ==================================================

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cpu_fpu_data_out <= '0;
        end else if (capture_result) begin
            cpu_fpu_data_out <= mask_to_size(fpu_result_data, size_q);  // Held through RESULT
        end
    end

endmodule

// ==== source/fpu_cpu_interface.sv ====
`timescale 1ns/1ps

module fpu_cpu_interface import fpu_if_pkg::*; (
    input  logic              clk,
    input  logic              reset,

    // ==================================================
    // CPU side
    // ==================================================
    input  logic              cpu_fpu_instr_valid,
    input  logic [7:0]        cpu_fpu_opcode,
    input  logic [7:0]        cpu_fpu_modrm,
    output logic              cpu_fpu_instr_ack,
    input  logic              cpu_fpu_data_write,
    input  logic              cpu_fpu_data_read,
    input  logic [DATA_W-1:0] cpu_fpu_data_in,
    output logic [DATA_W-1:0] cpu_fpu_data_out,
    output logic              cpu_fpu_data_ready,
    output logic [SIZE_W-1:0] cpu_fpu_operand_size,   // Decoded width of current op
    output logic              cpu_fpu_busy,
    output logic              cpu_fpu_ready,
    output logic [15:0]       cpu_fpu_status_word,
    input  logic [15:0]       cpu_fpu_control_word,
    input  logic              cpu_fpu_ctrl_write,
    output logic              cpu_fpu_exception,
    output logic              cpu_fpu_irq,

    // ==================================================
    // Core side
    // ==================================================
    output logic              fpu_start,
    output logic [7:0]        fpu_operation,
    output logic [7:0]        fpu_operand_select,
    output logic [DATA_W-1:0] fpu_operand_data,
    input  logic              fpu_operation_complete,
    input  logic [DATA_W-1:0] fpu_result_data,
    input  logic [15:0]       fpu_status,
    input  logic              fpu_error,
    output logic [15:0]       fpu_control_reg,
    output logic              fpu_control_update
);

    logic              needs_operand;
    logic              produces_result;
    logic [SIZE_W-1:0] op_size;
    logic              clear_operand;
    logic              capture_operand;
    logic              capture_result;
    logic [SIZE_W-1:0] size_q;

    // Decoder looks at the live bytes, sequencer latches on accept
    esc_decoder decoder_i (
        .opcode          (cpu_fpu_opcode),
        .modrm           (cpu_fpu_modrm),
        .needs_operand   (needs_operand),
        .produces_result (produces_result),
        .op_size         (op_size)
    );

    fpu_sequencer sequencer_i (
        .clk                    (clk),
        .reset                  (reset),
        .cpu_fpu_instr_valid    (cpu_fpu_instr_valid),
        .cpu_fpu_opcode         (cpu_fpu_opcode),
        .cpu_fpu_modrm          (cpu_fpu_modrm),
        .needs_operand          (needs_operand),
        .produces_result        (produces_result),
        .op_size                (op_size),
        .cpu_fpu_data_write     (cpu_fpu_data_write),
        .cpu_fpu_data_read      (cpu_fpu_data_read),
        .cpu_fpu_ctrl_write     (cpu_fpu_ctrl_write),
        .cpu_fpu_control_word   (cpu_fpu_control_word),
        .fpu_operation_complete (fpu_operation_complete),
        .fpu_status             (fpu_status),
        .fpu_error              (fpu_error),
        .cpu_fpu_instr_ack      (cpu_fpu_instr_ack),
        .cpu_fpu_busy           (cpu_fpu_busy),
        .cpu_fpu_ready          (cpu_fpu_ready),
        .cpu_fpu_data_ready     (cpu_fpu_data_ready),
        .cpu_fpu_operand_size   (cpu_fpu_operand_size),
        .cpu_fpu_status_word    (cpu_fpu_status_word),
        .cpu_fpu_exception      (cpu_fpu_exception),
        .cpu_fpu_irq            (cpu_fpu_irq),
        .fpu_start              (fpu_start),
        .fpu_operation          (fpu_operation),
        .fpu_operand_select     (fpu_operand_select),
        .fpu_control_reg        (fpu_control_reg),
        .fpu_control_update     (fpu_control_update),
        .clear_operand          (clear_operand),
        .capture_operand        (capture_operand),
        .capture_result         (capture_result),
        .size_q                 (size_q)
    );

    operand_path operand_path_i (
        .clk              (clk),
        .reset            (reset),
        .clear_operand    (clear_operand),
        .capture_operand  (capture_operand),
        .capture_result   (capture_result),
        .size_q           (size_q),
        .cpu_fpu_data_in  (cpu_fpu_data_in),
        .fpu_result_data  (fpu_result_data),
        .fpu_operand_data (fpu_operand_data),
        .cpu_fpu_data_out (cpu_fpu_data_out)
    );

endmodule

// ==== dv/fpu_sequencer_sva.sv ====
`timescale 1ns/1ps

module fpu_sequencer_sva import fpu_if_pkg::*; (
    input logic       clk,
    input logic       reset,
    input logic [2:0] state,
    input logic       cpu_fpu_instr_ack,
    input logic       cpu_fpu_busy,
    input logic       cpu_fpu_data_ready,
    input logic       cpu_fpu_ctrl_write,
    input logic       fpu_start,
    input logic       fpu_control_update
);

    // ==================================================
    // Pulses
    // ==================================================

    ack_pulse: assert property (@(posedge clk) disable iff (reset)
        cpu_fpu_instr_ack |=> !cpu_fpu_instr_ack)
        else $error("cpu_fpu_instr_ack high for more than one cycle");

    start_pulse: assert property (@(posedge clk) disable iff (reset)
        fpu_start |=> !fpu_start)
        else $error("fpu_start high for more than one cycle");

    // Only legal inside a transaction
    start_busy: assert property (@(posedge clk) disable iff (reset)
        fpu_start |-> cpu_fpu_busy)
        else $error("fpu_start while not busy");

    ready_busy: assert property (@(posedge clk) disable iff (reset)
        cpu_fpu_data_ready |-> cpu_fpu_busy)
        else $error("cpu_fpu_data_ready while not busy");

    update_after_idle_write: assert property (@(posedge clk) disable iff (reset)
        fpu_control_update |-> $past(cpu_fpu_ctrl_write && (state == ST_IDLE)))
        else $error("fpu_control_update without an idle control write");

endmodule

bind fpu_sequencer fpu_sequencer_sva sva_i (
    .clk                (clk),
    .reset              (reset),
    .state              (state),
    .cpu_fpu_instr_ack  (cpu_fpu_instr_ack),
    .cpu_fpu_busy       (cpu_fpu_busy),
    .cpu_fpu_data_ready (cpu_fpu_data_ready),
    .cpu_fpu_ctrl_write (cpu_fpu_ctrl_write),
    .fpu_start          (fpu_start),
    .fpu_control_update (fpu_control_update)
);

// ==== dv/fpu_cpu_interface_tb.sv ====
`timescale 1ns/1ps

module fpu_cpu_interface_tb import fpu_if_pkg::*;;

    logic              clk;
    logic              reset;
    logic              cpu_fpu_instr_valid;
    logic [7:0]        cpu_fpu_opcode;
    logic [7:0]        cpu_fpu_modrm;
    logic              cpu_fpu_instr_ack;
    logic              cpu_fpu_data_write;
    logic              cpu_fpu_data_read;
    logic [DATA_W-1:0] cpu_fpu_data_in;
    logic [DATA_W-1:0] cpu_fpu_data_out;
    logic              cpu_fpu_data_ready;
    logic [SIZE_W-1:0] cpu_fpu_operand_size;
    logic              cpu_fpu_busy;
    logic              cpu_fpu_ready;
    logic [15:0]       cpu_fpu_status_word;
    logic [15:0]       cpu_fpu_control_word;
    logic              cpu_fpu_ctrl_write;
    logic              cpu_fpu_exception;
    logic              cpu_fpu_irq;
    logic              fpu_start;
    logic [7:0]        fpu_operation;
    logic [7:0]        fpu_operand_select;
    logic [DATA_W-1:0] fpu_operand_data;
    logic              fpu_operation_complete;
    logic [DATA_W-1:0] fpu_result_data;
    logic [15:0]       fpu_status;
    logic              fpu_error;
    logic [15:0]       fpu_control_reg;
    logic              fpu_control_update;

    integer            seed = 32'h74dda0c8;
    integer            core_seed = 32'h74dda0c8;
    int                errors = 0;
    int                checks = 0;
    logic [DATA_W-1:0] core_result;     // Last value returned by the core model

    fpu_cpu_interface dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Keeps the low 16, 32 or 64 bits or the whole word
    function automatic logic [DATA_W-1:0] width_mask(input logic [SIZE_W-1:0] size);
        int bits;
        bits = (size == SIZE_80) ? DATA_W : (16 << size);
        return (bits == DATA_W) ? {DATA_W{1'b1}} : ((80'd1 << bits) - 80'd1);
    endfunction

    function automatic logic [DATA_W-1:0] random_data();
        logic [95:0] raw;
        raw = {$random(seed), $random(seed), $random(seed)};
        return raw[DATA_W-1:0];
    endfunction

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic check_word(input string name, input logic [DATA_W-1:0] expected,
                              input logic [DATA_W-1:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
        end
    endtask

    task automatic report_error(input string msg);
        errors++;
        $display("ERROR: %s", msg);
    endtask

    // ==================================================
    // Core model
    // ==================================================

    initial begin
        logic [95:0] raw;
        logic [31:0] r;
        int          latency;
        fpu_operation_complete = 1'b0;
        fpu_result_data        = '0;
        forever begin
            @(negedge clk);
            if (fpu_start) begin
                r = $random(core_seed);
                latency = r[1:0] + 1;           // 1 to 4 cycles
                repeat (latency) @(posedge clk);
                raw = {$random(core_seed), $random(core_seed), $random(core_seed)};
                core_result = raw[DATA_W-1:0];
                fpu_result_data        <= core_result;
                fpu_operation_complete <= 1'b1;
                @(posedge clk);
                fpu_operation_complete <= 1'b0;
            end
        end
    end

    // ==================================================
    // CPU-side transactions
    // ==================================================

    task automatic issue_instr(input logic [7:0] opcode, input logic [7:0] modrm);
        @(posedge clk);
        cpu_fpu_instr_valid <= 1'b1;
        cpu_fpu_opcode      <= opcode;
        cpu_fpu_modrm       <= modrm;
        @(posedge clk);
        cpu_fpu_instr_valid <= 1'b0;
        cpu_fpu_opcode      <= ~opcode;     // Scramble the bytes once the instruction is taken
        cpu_fpu_modrm       <= ~modrm;
        @(negedge clk);
        check_bit("cpu_fpu_instr_ack", 1'b1, cpu_fpu_instr_ack);
        check_bit("cpu_fpu_busy", 1'b1, cpu_fpu_busy);
        check_bit("cpu_fpu_ready", 1'b0, cpu_fpu_ready);
    endtask

    task automatic write_operand(input logic [DATA_W-1:0] data);
        @(posedge clk);
        cpu_fpu_data_write <= 1'b1;
        cpu_fpu_data_in    <= data;
        @(posedge clk);
        cpu_fpu_data_write <= 1'b0;
        @(negedge clk);
    endtask

    // Waits for busy to drop and flags a data_ready that has no result
    task automatic wait_idle(input bit result);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (cpu_fpu_data_ready && !result) report_error("data_ready raised with no result");
        end while (cpu_fpu_busy && n < 40);
        if (cpu_fpu_busy) report_error("busy did not drop at the end of the transaction");
        check_bit("cpu_fpu_ready", 1'b1, cpu_fpu_ready);
    endtask

    task automatic run_transaction(input logic [7:0] opcode, input logic [7:0] modrm,
                                   input bit need, input bit result,
                                   input logic [SIZE_W-1:0] size, input int read_delay);
        logic [DATA_W-1:0] operand;
        int                n;
        operand = random_data();
        issue_instr(opcode, modrm);
        check_word("cpu_fpu_operand_size", DATA_W'(size), DATA_W'(cpu_fpu_operand_size));
        if (need) begin
            repeat (5) begin
                @(negedge clk);
                if (fpu_start) report_error("fpu_start raised before the operand write");
            end
            write_operand(operand);
        end
        n = 0;
        while (!fpu_start && n < 20) begin
            @(negedge clk);
            n++;
        end
        if (!fpu_start) report_error("fpu_start never appeared");
        check_word("fpu_operation", DATA_W'(opcode), DATA_W'(fpu_operation));
        check_word("fpu_operand_select", DATA_W'(modrm), DATA_W'(fpu_operand_select));
        check_word("fpu_operand_data", need ? (operand & width_mask(size)) : '0,
                   fpu_operand_data);
        if (result) begin
            n = 0;
            while (!cpu_fpu_data_ready && n < 20) begin
                @(negedge clk);
                n++;
            end
            for (int i = 0; i <= read_delay; i++) begin
                if (i > 0) @(negedge clk);     // Data must hold while the read is withheld
                check_bit("cpu_fpu_data_ready", 1'b1, cpu_fpu_data_ready);
                check_word("cpu_fpu_data_out", core_result & width_mask(size), cpu_fpu_data_out);
            end
            @(posedge clk);
            cpu_fpu_data_read <= 1'b1;
            @(posedge clk);
            cpu_fpu_data_read <= 1'b0;
        end
        wait_idle(result);
    endtask

    // ==================================================
    // Tests
    // ==================================================

    task automatic test_reset_values();
        @(negedge clk);
        check_word("fpu_control_reg", DATA_W'(16'h037F), DATA_W'(fpu_control_reg));
        check_bit("cpu_fpu_busy", 1'b0, cpu_fpu_busy);
        check_bit("cpu_fpu_instr_ack", 1'b0, cpu_fpu_instr_ack);
        check_bit("cpu_fpu_data_ready", 1'b0, cpu_fpu_data_ready);
        check_bit("fpu_start", 1'b0, fpu_start);
        check_bit("cpu_fpu_ready", 1'b1, cpu_fpu_ready);
        check_word("fpu_operand_data", '0, fpu_operand_data);
        check_word("cpu_fpu_data_out", '0, cpu_fpu_data_out);
    endtask

    // One row per decode rule
    task automatic test_decode_table();
        run_transaction(8'hD8, 8'h06, 1, 0, SIZE_32, 0);
        run_transaction(8'hDA, 8'h45, 1, 0, SIZE_32, 0);
        run_transaction(8'hDC, 8'h86, 1, 0, SIZE_64, 0);
        run_transaction(8'hDE, 8'h06, 1, 0, SIZE_16, 0);
        run_transaction(8'hDF, 8'h06, 1, 0, SIZE_16, 0);
        run_transaction(8'hD9, 8'h06, 1, 0, SIZE_32, 0);
        run_transaction(8'hD9, 8'h16, 0, 1, SIZE_32, 0);
        run_transaction(8'hD9, 8'h2E, 1, 0, SIZE_16, 0);
        run_transaction(8'hD9, 8'h3E, 0, 1, SIZE_16, 0);
        run_transaction(8'hD9, 8'h26, 0, 0, SIZE_16, 0);
        run_transaction(8'hDB, 8'h2E, 1, 0, SIZE_80, 0);
        run_transaction(8'hDB, 8'h3E, 0, 1, SIZE_80, 0);
        run_transaction(8'hDB, 8'h06, 1, 0, SIZE_32, 0);
        run_transaction(8'hDD, 8'h06, 1, 0, SIZE_64, 0);
        run_transaction(8'hDD, 8'h16, 0, 1, SIZE_64, 0);
        run_transaction(8'hDD, 8'h3E, 0, 1, SIZE_16, 0);
        run_transaction(8'hDD, 8'h26, 0, 0, SIZE_16, 0);
        run_transaction(8'hDF, 8'hE0, 0, 1, SIZE_16, 0);   // FSTSW AX
        run_transaction(8'hD8, 8'hC1, 0, 0, SIZE_16, 0);   // Register form
        run_transaction(8'h9B, 8'h06, 0, 0, SIZE_16, 0);   // Not an ESC opcode
    endtask

    task automatic test_operand_masking();
        run_transaction(8'hD9, 8'h2E, 1, 0, SIZE_16, 0);
        run_transaction(8'hDA, 8'h05, 1, 0, SIZE_32, 0);
        run_transaction(8'hDC, 8'h06, 1, 0, SIZE_64, 0);
        run_transaction(8'hDB, 8'h2E, 1, 0, SIZE_80, 0);
        run_transaction(8'hD9, 8'hE8, 0, 0, SIZE_16, 0);   // FLD1 sends zero
    endtask

    task automatic test_result_backpressure();
        logic [31:0] r;
        r = $random(seed);
        run_transaction(8'hD9, 8'h3E, 0, 1, SIZE_16, r % 7);
        r = $random(seed);
        run_transaction(8'hD9, 8'h16, 0, 1, SIZE_32, r % 7);
        r = $random(seed);
        run_transaction(8'hDD, 8'h16, 0, 1, SIZE_64, r % 7);
        r = $random(seed);
        run_transaction(8'hDB, 8'h3E, 0, 1, SIZE_80, r % 7);
    endtask

    task automatic test_control_word();
        @(posedge clk);
        cpu_fpu_ctrl_write   <= 1'b1;
        cpu_fpu_control_word <= 16'h0A5C;
        @(posedge clk);
        cpu_fpu_ctrl_write <= 1'b0;
        @(negedge clk);
        check_word("fpu_control_reg", DATA_W'(16'h0A5C), DATA_W'(fpu_control_reg));
        check_bit("fpu_control_update", 1'b1, fpu_control_update);
        @(negedge clk);
        check_bit("fpu_control_update", 1'b0, fpu_control_update);
        // A second write is ignored in OPERAND_WAIT
        issue_instr(8'hD8, 8'h06);
        @(posedge clk);
        cpu_fpu_ctrl_write   <= 1'b1;
        cpu_fpu_control_word <= 16'h1234;
        @(posedge clk);
        cpu_fpu_ctrl_write <= 1'b0;
        repeat (2) begin
            @(negedge clk);
            check_word("fpu_control_reg", DATA_W'(16'h0A5C), DATA_W'(fpu_control_reg));
            check_bit("fpu_control_update", 1'b0, fpu_control_update);
        end
        write_operand(random_data());
        wait_idle(0);
    endtask

    task automatic test_exception();
        logic [15:0] status;
        for (int i = 0; i < 4; i++) begin
            status = {8'h3C, i[1], 7'h15};
            @(posedge clk);
            fpu_error  <= i[0];
            fpu_status <= status;
            @(negedge clk);
            check_bit("cpu_fpu_exception", i[0] & ~i[1], cpu_fpu_exception);
            check_bit("cpu_fpu_irq", i[0] & ~i[1], cpu_fpu_irq);
            check_word("cpu_fpu_status_word", DATA_W'(status), DATA_W'(cpu_fpu_status_word));
        end
        @(posedge clk);
        fpu_error  <= 1'b0;
        fpu_status <= 16'h0000;
    endtask

    // ==================================================
    // Main sequence and watchdog
    // ==================================================

    initial begin
        reset                = 1'b1;
        cpu_fpu_instr_valid  = 1'b0;
        cpu_fpu_opcode       = 8'h00;
        cpu_fpu_modrm        = 8'h00;
        cpu_fpu_data_write   = 1'b0;
        cpu_fpu_data_read    = 1'b0;
        cpu_fpu_data_in      = '0;
        cpu_fpu_control_word = 16'h0000;
        cpu_fpu_ctrl_write   = 1'b0;
        fpu_status           = 16'h0000;
        fpu_error            = 1'b0;
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        test_reset_values();
        test_decode_table();
        test_operand_masking();
        test_result_backpressure();
        test_control_word();
        test_exception();
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

    initial begin
        #(60 * 40 * 10);    // 60 transactions of up to 40 cycles each
        $display("Watchdog expired before the tests finished");
        $display("Done: errors found");
        $finish;
    end

endmodule

// ==== build.f ====
source/fpu_if_pkg.sv
source/esc_decoder.sv
source/fpu_sequencer.sv
source/operand_path.sv
source/fpu_cpu_interface.sv
dv/fpu_sequencer_sva.sv
dv/fpu_cpu_interface_tb.sv

// ==== Makefile ====
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build folder and the log"

test:
	verilator --binary --timing --assert --top-module fpu_cpu_interface_tb \
		-f build.f --Mdir $(BUILD_DIR) -o sim
	./$(BUILD_DIR)/sim > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Done: no errors" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
